/* instructionDecode.f */
common/isaPkg.sv
common/datapathPkg.sv
decode/controller.sv
decode/registerFile.sv
decode/immExtend.sv
decode/idExRegister.sv
rtl/instructionDecode.sv
tb/instructionDecode_assertions.sv
tb/instructionDecodeTb.sv

/* Makefile */
# Verilator simulation of the ID stage testbench

VERILATOR ?= verilator
TOP       ?= instructionDecodeTb
FILELIST  ?= instructionDecode.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/instructionDecodeTb.sv */
`timescale 1ns/1ps

module instructionDecodeTb import isaPkg::*, datapathPkg::*; ();

  // Control bundle order {pcSel, regDst, aluSrc0, aluSrc1, aluCtrl, memRead, memWrite,
  // memWidth, memToReg, regWrite, branchSel}
  localparam logic [18:0] cNone = 19'b0_0_0_00_0000_0_0_00_0_0_0000; // Bubble, unknown op
  localparam logic [18:0] cAdd  = 19'b0_1_0_00_0000_0_0_00_0_1_0000;
  localparam logic [18:0] cSub  = 19'b0_1_0_00_0001_0_0_00_0_1_0000;
  localparam logic [18:0] cAnd  = 19'b0_1_0_00_0010_0_0_00_0_1_0000;
  localparam logic [18:0] cOr   = 19'b0_1_0_00_0011_0_0_00_0_1_0000;
  localparam logic [18:0] cSlt  = 19'b0_1_0_00_0100_0_0_00_0_1_0000;
  localparam logic [18:0] cSll  = 19'b0_1_1_00_0101_0_0_00_0_1_0000; // shamt operand
  localparam logic [18:0] cJump = 19'b1_0_0_00_0000_0_0_00_0_0_0000; // j and jr
  localparam logic [18:0] cJal  = 19'b1_1_0_10_0000_0_0_00_0_1_0000; // Link to r31
  localparam logic [18:0] cAddi = 19'b0_0_0_01_0000_0_0_00_0_1_0000;
  localparam logic [18:0] cAndi = 19'b0_0_0_01_0010_0_0_00_0_1_0000;
  localparam logic [18:0] cOri  = 19'b0_0_0_01_0011_0_0_00_0_1_0000;
  localparam logic [18:0] cLui  = 19'b0_0_0_01_0110_0_0_00_0_1_0000;
  localparam logic [18:0] cLw   = 19'b0_0_0_01_0000_1_0_11_1_1_0000;
  localparam logic [18:0] cLh   = 19'b0_0_0_01_0000_1_0_10_1_1_0000;
  localparam logic [18:0] cLb   = 19'b0_0_0_01_0000_1_0_01_1_1_0000;
  localparam logic [18:0] cSw   = 19'b0_0_0_01_0000_0_1_11_0_0_0000;
  localparam logic [18:0] cSh   = 19'b0_0_0_01_0000_0_1_10_0_0_0000;
  localparam logic [18:0] cSb   = 19'b0_0_0_01_0000_0_1_01_0_0_0000;
  localparam logic [18:0] cBeq  = 19'b0_0_0_00_0001_0_0_00_0_0_0001;
  localparam logic [18:0] cBne  = 19'b0_0_0_00_0001_0_0_00_0_0_0010;
  localparam logic [18:0] cBgez = 19'b0_0_0_00_0001_0_0_00_0_0_0100;
  localparam logic [18:0] cBltz = 19'b0_0_0_00_0001_0_0_00_0_0_1000;

  localparam logic [1:0] kSign  = 2'd0; // Expected immediate extension
  localparam logic [1:0] kZero  = 2'd1;
  localparam logic [1:0] kUpper = 2'd2;

  typedef struct packed {
    logic [31:0] instr;
    logic [4:0]  wbAddr;
    logic        wbEnable;
    logic        stall;
    logic        flush;
    logic [18:0] ctrl;
    logic [1:0]  immKind;
  } stepT;

  typedef struct packed {
    logic [18:0] ctrl;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] imm;
    logic [4:0]  rt;
    logic [4:0]  rd;
  } expectT;

  logic      Clock, rstN;
  wordT      instruction, wbData;
  regAddrT   wbAddr;
  logic      wbEnable, stall, flush;
  logic      exPcSel, exRegDst, exAluSrc0, exMemRead, exMemWrite, exMemToReg, exRegWrite;
  aluSrc1T   exAluSrc1;
  aluCtrlE   exAluCtrl;
  memWidthT  exMemWidth;
  branchSelT exBranchSel;
  wordT      exRsData, exRtData, exImm;
  regAddrT   exRt, exRd;

  stepT        steps[$];                // Stimulus table
  expectT      expected, pending;       // Now visible, and next after capture
  logic [31:0] shadow [32];             // Model of the register file
  logic [31:0] lfsrState = 32'd27;
  int          cycleCount = 0;
  int          timeoutLimit = 20;

  instructionDecode #(.writeThrough(1'b1)) u_instructionDecode (
    .Clock(Clock), .rstN(rstN), .instruction(instruction),
    .wbAddr(wbAddr), .wbData(wbData), .wbEnable(wbEnable), .stall(stall), .flush(flush),
    .exPcSel(exPcSel), .exRegDst(exRegDst), .exAluSrc0(exAluSrc0), .exAluSrc1(exAluSrc1),
    .exAluCtrl(exAluCtrl), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
    .exMemWidth(exMemWidth), .exMemToReg(exMemToReg), .exRegWrite(exRegWrite),
    .exBranchSel(exBranchSel), .exRsData(exRsData), .exRtData(exRtData),
    .exImm(exImm), .exRt(exRt), .exRd(exRd)
  );

  always #50 Clock = ~Clock; // 100 ns period

  // Run limit
  always @(posedge Clock) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout: outputs not all checked within %0d cycles", timeoutLimit);
      $display("Done: errors found");
      $fatal(1, "Timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task automatic nextRandomWord(output logic [31:0] value);
    for (int b = 0; b < 32; b++) begin
      value[b] = lfsrState[0];          // One step per bit
      lfsrState = galoisStep(lfsrState);
    end
  endtask

  function automatic logic [31:0] rType(input logic [4:0] rs, rt, rd, shamt,
                                        input logic [5:0] fn);
    return {6'h00, rs, rt, rd, shamt, fn};
  endfunction

  function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs, rt,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jType(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic addStep(input logic [31:0] instr, input logic [4:0] wbA,
                         input logic wbEn, stallIn, flushIn,
                         input logic [18:0] ctrl, input logic [1:0] immKind);
    stepT s;
    s = '{instr, wbA, wbEn, stallIn, flushIn, ctrl, immKind};
    steps.push_back(s);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expectedValue,
                            input logic [31:0] actualValue);
    if (actualValue !== expectedValue) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, expectedValue, actualValue);
      $display("Done: errors found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic compareOutputs(input expectT e);
    checkValue("exPcSel",     32'(e.ctrl[18]),    32'(exPcSel));
    checkValue("exRegDst",    32'(e.ctrl[17]),    32'(exRegDst));
    checkValue("exAluSrc0",   32'(e.ctrl[16]),    32'(exAluSrc0));
    checkValue("exAluSrc1",   32'(e.ctrl[15:14]), 32'(exAluSrc1));
    checkValue("exAluCtrl",   32'(e.ctrl[13:10]), 32'(exAluCtrl));
    checkValue("exMemRead",   32'(e.ctrl[9]),     32'(exMemRead));
    checkValue("exMemWrite",  32'(e.ctrl[8]),     32'(exMemWrite));
    checkValue("exMemWidth",  32'(e.ctrl[7:6]),   32'(exMemWidth));
    checkValue("exMemToReg",  32'(e.ctrl[5]),     32'(exMemToReg));
    checkValue("exRegWrite",  32'(e.ctrl[4]),     32'(exRegWrite));
    checkValue("exBranchSel", 32'(e.ctrl[3:0]),   32'(exBranchSel));
    checkValue("exRsData",    e.rsData,           exRsData);
    checkValue("exRtData",    e.rtData,           exRtData);
    checkValue("exImm",       e.imm,              exImm);
    checkValue("exRt",        32'(e.rt),          32'(exRt));
    checkValue("exRd",        32'(e.rd),          32'(exRd));
  endtask

  // Next ID/EX contents, shadow already holds this step's write
  task automatic predictStep(input stepT s);
    logic [4:0]  rtRead;
    logic [15:0] imm;
    imm    = s.instr[15:0];
    rtRead = (s.instr[31:26] == 6'h00 && s.instr[5:0] == 6'h08) ? 5'd0 : s.instr[20:16];
    if (s.flush) begin
      pending = '0;                     // Flush beats stall
    end else if (s.stall) begin
      pending = expected;               // Hold
    end else begin
      pending.ctrl   = s.ctrl;
      pending.rsData = shadow[s.instr[25:21]];
      pending.rtData = shadow[rtRead];
      pending.rt     = s.instr[20:16];
      pending.rd     = s.instr[15:11];
      case (s.immKind)
        kZero:   pending.imm = {16'h0000, imm};
        kUpper:  pending.imm = {imm, 16'h0000};
        default: pending.imm = {{16{imm[15]}}, imm};
      endcase
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  task automatic buildTable();
    // instr, wbAddr, wbEnable, stall, flush, controls, extension
    addStep(rType(1, 2, 3, 0, functAdd), 1, 1, 0, 0, cAdd, kSign);  // Reads r1 as written
    addStep(rType(1, 2, 4, 0, functSub), 2, 1, 0, 0, cSub, kSign);
    addStep(rType(0, 1, 5, 0, functAnd), 0, 1, 0, 0, cAnd, kSign);  // r0 write dropped
    addStep(rType(5, 2, 6, 0, functOr),  5, 1, 0, 0, cOr,  kSign);
    addStep(rType(1, 5, 7, 0, functSlt), 0, 0, 0, 0, cSlt, kSign);
    addStep(rType(0, 2, 8, 4, functSll), 0, 0, 0, 0, cSll, kSign);
    addStep(rType(1, 2, 0, 0, functJr),  0, 0, 0, 0, cJump, kSign); // rt read forced to r0
    addStep(iType(opAddi, 1, 9, 16'h8001),  9, 1, 0, 0, cAddi, kSign);
    addStep(iType(opAndi, 2, 10, 16'h8001), 0, 0, 0, 0, cAndi, kZero);
    addStep(iType(opOri, 5, 11, 16'hf0f0),  0, 0, 0, 0, cOri,  kZero);
    addStep(iType(opLui, 0, 12, 16'h1234),  0, 0, 0, 0, cLui,  kUpper);
    addStep(iType(opLw, 1, 13, 16'hfffc),   0, 0, 0, 0, cLw, kSign);
    addStep(iType(opLh, 2, 14, 16'h0002),   0, 0, 0, 0, cLh, kSign);
    addStep(iType(opLb, 5, 15, 16'h8000),   0, 0, 0, 0, cLb, kSign);
    addStep(iType(opSw, 1, 2, 16'h0008),    0, 0, 0, 0, cSw, kSign);
    addStep(iType(opSh, 5, 9, 16'h7fff),    0, 0, 0, 0, cSh, kSign);
    addStep(iType(opSb, 9, 1, 16'hffff),    0, 0, 0, 0, cSb, kSign);
    addStep(iType(opBeq, 1, 2, 16'h0010),   0, 0, 0, 0, cBeq, kSign);
    addStep(iType(opBne, 5, 1, 16'hfff0),   0, 0, 0, 0, cBne, kSign);
    addStep(iType(opRegImm, 9, rtBgez, 16'h0020), 0, 0, 0, 0, cBgez, kSign);
    addStep(iType(opRegImm, 1, rtBltz, 16'h8004), 0, 0, 0, 0, cBltz, kSign);
    addStep(jType(opJ, 26'h0123456),   0, 0, 0, 0, cJump, kSign);
    addStep(jType(opJal, 26'h0000100), 0, 0, 0, 0, cJal, kSign);
    // Stall holds jal, register write still lands
    addStep(iType(opAddi, 3, 3, 16'h0001), 3, 1, 1, 0, cAddi, kSign);
    addStep(iType(opLw, 2, 4, 16'h0004),   0, 0, 1, 0, cLw, kSign);
    addStep(iType(opLw, 1, 13, 16'h0004),  0, 0, 0, 1, cLw, kSign);
    addStep(rType(3, 9, 16, 0, functAdd),  0, 0, 0, 0, cAdd, kSign); // r3 from stall cycle
    addStep(rType(1, 2, 3, 0, functAdd),   0, 0, 1, 1, cAdd, kSign); // Flush beats stall
    addStep({6'h3f, 5'd1, 5'd2, 16'h1234}, 0, 0, 0, 0, cNone, kSign); // Unknown opcode
    addStep(32'h0000_0000,                 0, 0, 0, 0, cSll, kSign);  // nop is sll r0
  endtask

  initial begin
    logic [31:0] data;
    Clock       = 1'b0;
    rstN        = 1'b0;
    instruction = '0;
    wbAddr      = '0;
    wbData      = '0;
    wbEnable    = 1'b0;
    stall       = 1'b0;
    flush       = 1'b0;
    expected    = '0;                   // Reset state
    pending     = '0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    buildTable();
    timeoutLimit = 2 * steps.size() + 20;

    repeat (2) @(posedge Clock);
    for (int k = 0; k <= steps.size(); k++) begin
      @(posedge Clock);
      rstN <= 1'b1;                     // Third edge still sees reset
      if (k < steps.size()) begin
        data = '0;
        if (steps[k].wbEnable) begin
          nextRandomWord(data);
        end
        if (steps[k].wbEnable && steps[k].wbAddr != 5'd0) begin
          shadow[steps[k].wbAddr] = data;
        end
        instruction <= steps[k].instr;
        wbAddr      <= steps[k].wbAddr;
        wbData      <= data;
        wbEnable    <= steps[k].wbEnable;
        stall       <= steps[k].stall;
        flush       <= steps[k].flush;
        predictStep(steps[k]);
      end
      @(negedge Clock);
      compareOutputs(expected);         // Result of previous step
      expected = pending;
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

/* tb/instructionDecode_assertions.sv */
`timescale 1ns/1ps

module instructionDecode_assertions import datapathPkg::*; (
  input logic      Clock,
  input logic      rstN,
  input logic      flush,
  input logic      exPcSel,
  input logic      exRegDst,
  input logic      exAluSrc0,
  input aluSrc1T   exAluSrc1,
  input logic [3:0] exAluCtrl,
  input logic      exMemRead,
  input logic      exMemWrite,
  input memWidthT  exMemWidth,
  input logic      exMemToReg,
  input logic      exRegWrite,
  input branchSelT exBranchSel
);

  logic [18:0] controls;

  assign controls = {exPcSel, exRegDst, exAluSrc0, exAluSrc1, exAluCtrl, exMemRead,
                     exMemWrite, exMemWidth, exMemToReg, exRegWrite, exBranchSel};

  //////////////////////////////////////////////////////////////////////
  // Bubble after reset or flush
  bubbleAfterClear: assert property (@(posedge Clock) (!rstN || flush) |=> (controls == '0))
    else $error("ID/EX controls active the cycle after reset or flush");

  noReadAndWrite: assert property (@(posedge Clock) disable iff (!rstN)
    !(exMemRead && exMemWrite))
    else $error("exMemRead and exMemWrite both set");

  // Zero or one branch condition
  branchOneHot: assert property (@(posedge Clock) disable iff (!rstN) $onehot0(exBranchSel))
    else $error("exBranchSel not one-hot: %b", exBranchSel);

endmodule

bind idExRegister instructionDecode_assertions u_assertions (
  .Clock(Clock), .rstN(rstN), .flush(flush),
  .exPcSel(exPcSel), .exRegDst(exRegDst), .exAluSrc0(exAluSrc0), .exAluSrc1(exAluSrc1),
  .exAluCtrl(exAluCtrl), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
  .exMemWidth(exMemWidth), .exMemToReg(exMemToReg), .exRegWrite(exRegWrite),
  .exBranchSel(exBranchSel)
);

/* rtl/instructionDecode.sv */
`timescale 1ns/1ps

module instructionDecode import isaPkg::*, datapathPkg::*; #(
  parameter bit writeThrough = 1'b1
) (
  input  logic      Clock,
  input  logic      rstN,
  input  wordT      instruction,
  input  regAddrT   wbAddr,      // From writeback
  input  wordT      wbData,
  input  logic      wbEnable,
  input  logic      stall,       // Hold ID/EX
  input  logic      flush,       // Load a bubble
  output logic      exPcSel,
  output logic      exRegDst,
  output logic      exAluSrc0,
  output aluSrc1T   exAluSrc1,
  output aluCtrlE   exAluCtrl,
  output logic      exMemRead,
  output logic      exMemWrite,
  output memWidthT  exMemWidth,
  output logic      exMemToReg,
  output logic      exRegWrite,
  output branchSelT exBranchSel,
  output wordT      exRsData,
  output wordT      exRtData,
  output wordT      exImm,
  output regAddrT   exRt,
  output regAddrT   exRd
);

  regAddrT   rsAddr, rtAddr;
  logic      pcSel, regDst, aluSrc0, memRead, memWrite, memToReg, regWrite;
  aluSrc1T   aluSrc1;
  aluCtrlE   aluCtrl;
  memWidthT  memWidth;
  branchSelT branchSel;
  immKindE   immKind;
  wordT      rsData, rtData, immOut;

  //////////////////////////////////////////////////////////////////////
  // Decode
  controller u_controller (
    .instruction(instruction), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .pcSel(pcSel), .regDst(regDst), .aluSrc0(aluSrc0), .aluSrc1(aluSrc1),
    .aluCtrl(aluCtrl), .memRead(memRead), .memWrite(memWrite), .memWidth(memWidth),
    .memToReg(memToReg), .regWrite(regWrite), .branchSel(branchSel), .immKind(immKind)
  );

  registerFile #(.writeThrough(writeThrough)) u_registerFile (
    .Clock(Clock), .rstN(rstN), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .wbAddr(wbAddr), .wbData(wbData), .wbEnable(wbEnable),
    .rsData(rsData), .rtData(rtData)
  );

  immExtend u_immExtend (
    .imm(instruction[15:0]), .immKind(immKind), .immOut(immOut)
  );

  // Pipeline register, rt and rd fields straight from the instruction
  idExRegister u_idExRegister (
    .Clock(Clock), .rstN(rstN), .stall(stall), .flush(flush),
    .pcSel(pcSel), .regDst(regDst), .aluSrc0(aluSrc0), .aluSrc1(aluSrc1),
    .aluCtrl(aluCtrl), .memRead(memRead), .memWrite(memWrite), .memWidth(memWidth),
    .memToReg(memToReg), .regWrite(regWrite), .branchSel(branchSel),
    .rsData(rsData), .rtData(rtData), .immOut(immOut),
    .rt(instruction[20:16]), .rd(instruction[15:11]),
    .exPcSel(exPcSel), .exRegDst(exRegDst), .exAluSrc0(exAluSrc0),
    .exAluSrc1(exAluSrc1), .exAluCtrl(exAluCtrl), .exMemRead(exMemRead),
    .exMemWrite(exMemWrite), .exMemWidth(exMemWidth), .exMemToReg(exMemToReg),
    .exRegWrite(exRegWrite), .exBranchSel(exBranchSel), .exRsData(exRsData),
    .exRtData(exRtData), .exImm(exImm), .exRt(exRt), .exRd(exRd)
  );

endmodule

/* decode/idExRegister.sv */
`timescale 1ns/1ps

module idExRegister import isaPkg::*, datapathPkg::*; (
  input  logic      Clock,
  input  logic      rstN,
  input  logic      stall,
  input  logic      flush,
  input  logic      pcSel,
  input  logic      regDst,
  input  logic      aluSrc0,
  input  aluSrc1T   aluSrc1,
  input  aluCtrlE   aluCtrl,
  input  logic      memRead,
  input  logic      memWrite,
  input  memWidthT  memWidth,
  input  logic      memToReg,
  input  logic      regWrite,
  input  branchSelT branchSel,
  input  wordT      rsData,
  input  wordT      rtData,
  input  wordT      immOut,
  input  regAddrT   rt,
  input  regAddrT   rd,
  output logic      exPcSel,
  output logic      exRegDst,
  output logic      exAluSrc0,
  output aluSrc1T   exAluSrc1,
  output aluCtrlE   exAluCtrl,
  output logic      exMemRead,
  output logic      exMemWrite,
  output memWidthT  exMemWidth,
  output logic      exMemToReg,
  output logic      exRegWrite,
  output branchSelT exBranchSel,
  output wordT      exRsData,
  output wordT      exRtData,
  output wordT      exImm,
  output regAddrT   exRt,
  output regAddrT   exRd
);

  //////////////////////////////////////////////////////////////////////
  // Reset, then flush, then stall
  always_ff @(posedge Clock) begin
    if (!rstN || flush) begin  // Bubble, controls and data all zero
      exPcSel     <= 1'b0;
      exRegDst    <= 1'b0;
      exAluSrc0   <= 1'b0;
      exAluSrc1   <= srcReg;
      exAluCtrl   <= aluAdd;
      exMemRead   <= 1'b0;
      exMemWrite  <= 1'b0;
      exMemWidth  <= memNone;
      exMemToReg  <= 1'b0;
      exRegWrite  <= 1'b0;
      exBranchSel <= brNone;
      exRsData    <= '0;
      exRtData    <= '0;
      exImm       <= '0;
      exRt        <= '0;
      exRd        <= '0;
    end else if (!stall) begin // Stall holds everything
      exPcSel     <= pcSel;
      exRegDst    <= regDst;
      exAluSrc0   <= aluSrc0;
      exAluSrc1   <= aluSrc1;
      exAluCtrl   <= aluCtrl;
      exMemRead   <= memRead;
      exMemWrite  <= memWrite;
      exMemWidth  <= memWidth;
      exMemToReg  <= memToReg;
      exRegWrite  <= regWrite;
      exBranchSel <= branchSel;
      exRsData    <= rsData;
      exRtData    <= rtData;
      exImm       <= immOut;
      exRt        <= rt;
      exRd        <= rd;
    end
  end

endmodule

/* decode/immExtend.sv */
`timescale 1ns/1ps

module immExtend import isaPkg::*, datapathPkg::*; (
  input  logic [15:0] imm,
  input  immKindE     immKind,
  output wordT        immOut
);

  always_comb begin
    case (immKind)
      immZero:  immOut = {16'h0000, imm};   // andi, ori
      immUpper: immOut = {imm, 16'h0000};   // lui
      default:  immOut = {{16{imm[15]}}, imm};
    endcase
  end

endmodule

/* decode/registerFile.sv */
`timescale 1ns/1ps

module registerFile import datapathPkg::*; #(
  parameter bit writeThrough = 1'b1  // Same-cycle bypass of the writeback port
) (
  input  logic    Clock,
  input  logic    rstN,
  input  regAddrT rsAddr,
  input  regAddrT rtAddr,
  input  regAddrT wbAddr,
  input  wordT    wbData,
  input  logic    wbEnable,
  output wordT    rsData,
  output wordT    rtData
);

  wordT regs [32];

  // Write port, r0 never written
  always_ff @(posedge Clock) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEnable && (wbAddr != '0)) begin
      regs[wbAddr] <= wbData;
    end
  end

  function automatic wordT readReg(input regAddrT addr);
    wordT value;
    if (addr == '0) begin
      value = '0;                       // Hardwired zero
    end else if (writeThrough && wbEnable && (wbAddr == addr)) begin
      value = wbData;                   // Bypass
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb rsData = readReg(rsAddr);
  always_comb rtData = readReg(rtAddr);

endmodule

/* decode/controller.sv */
`timescale 1ns/1ps

module controller import isaPkg::*, datapathPkg::*; (
  input  wordT      instruction,
  output regAddrT   rsAddr,
  output regAddrT   rtAddr,
  output logic      pcSel,     // Jump, target from j field or rs
  output logic      regDst,    // 1 picks rd, r31 when aluSrc1 is link
  output logic      aluSrc0,   // 1 picks shamt
  output aluSrc1T   aluSrc1,
  output aluCtrlE   aluCtrl,
  output logic      memRead,
  output logic      memWrite,
  output memWidthT  memWidth,
  output logic      memToReg,
  output logic      regWrite,
  output branchSelT branchSel,
  output immKindE   immKind
);

  opcodeT     opcode;
  functT      funct;
  logic [4:0] rtField;
  logic       isJr;

  assign opcode  = instruction[31:26];
  assign funct   = instruction[5:0];
  assign rtField = instruction[20:16];
  assign isJr    = (opcode == opRType) && (funct == functJr);

  // Source addresses, rt unused by jr
  assign rsAddr = instruction[25:21];
  assign rtAddr = isJr ? '0 : rtField;

  //////////////////////////////////////////////////////////////////////
  // Control decode
  always_comb begin
    pcSel     = 1'b0; // Everything inactive unless decoded
    regDst    = 1'b0;
    aluSrc0   = 1'b0;
    aluSrc1   = srcReg;
    aluCtrl   = aluAdd;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    memWidth  = memNone;
    memToReg  = 1'b0;
    regWrite  = 1'b0;
    branchSel = brNone;
    immKind   = immSign;
    case (opcode)
      opRType: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (funct)
          functAdd: aluCtrl = aluAdd;
          functSub: aluCtrl = aluSub;
          functAnd: aluCtrl = aluAnd;
          functOr:  aluCtrl = aluOr;
          functSlt: aluCtrl = aluSlt;
          functSll: begin
            aluCtrl = aluSll;
            aluSrc0 = 1'b1;   // Shift amount from shamt
          end
          functJr: begin
            pcSel    = 1'b1;  // Target in rs
            regDst   = 1'b0;
            regWrite = 1'b0;
          end
          default: begin      // Unknown funct
            regDst   = 1'b0;
            regWrite = 1'b0;
          end
        endcase
      end
      opRegImm: begin
        aluCtrl = aluSub;
        case (rtField)
          rtBltz:  branchSel = brLtz;
          rtBgez:  branchSel = brGez;
          default: branchSel = brNone;
        endcase
      end
      opJ: pcSel = 1'b1;
      opJal: begin
        pcSel    = 1'b1;
        regDst   = 1'b1;      // With link source means r31
        aluSrc1  = srcLink;
        regWrite = 1'b1;
      end
      opBeq: begin
        aluCtrl   = aluSub;
        branchSel = brEq;
      end
      opBne: begin
        aluCtrl   = aluSub;
        branchSel = brNe;
      end
      opAddi, opAndi, opOri, opLui: begin
        aluSrc1  = srcImm;
        regWrite = 1'b1;
        case (opcode)
          opAndi: begin
            aluCtrl = aluAnd;
            immKind = immZero;
          end
          opOri: begin
            aluCtrl = aluOr;
            immKind = immZero;
          end
          opLui: begin
            aluCtrl = aluLui;
            immKind = immUpper;
          end
          default: aluCtrl = aluAdd; // addi
        endcase
      end
      opLb, opLh, opLw: begin
        aluSrc1  = srcImm;    // Base plus offset
        memRead  = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memWidth = (opcode == opLw) ? memWord : (opcode == opLh) ? memHalf : memByte;
      end
      opSb, opSh, opSw: begin
        aluSrc1  = srcImm;
        memWrite = 1'b1;
        memWidth = (opcode == opSw) ? memWord : (opcode == opSh) ? memHalf : memByte;
      end
      default: ;              // Unknown opcode, defaults stand
    endcase
  end

endmodule

/* common/datapathPkg.sv */
package datapathPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;
  typedef logic [1:0]  memWidthT;
  typedef logic [3:0]  branchSelT; // One-hot, zero is no branch
  typedef logic [1:0]  aluSrc1T;

  localparam memWidthT memNone = 2'd0;
  localparam memWidthT memByte = 2'd1;
  localparam memWidthT memHalf = 2'd2;
  localparam memWidthT memWord = 2'd3;

  localparam branchSelT brNone = 4'b0000;
  localparam branchSelT brEq   = 4'b0001;
  localparam branchSelT brNe   = 4'b0010;
  localparam branchSelT brGez  = 4'b0100;
  localparam branchSelT brLtz  = 4'b1000;

  localparam aluSrc1T srcReg  = 2'd0; // rt data
  localparam aluSrc1T srcImm  = 2'd1; // Extended immediate
  localparam aluSrc1T srcLink = 2'd2; // Return address for jal

endpackage

/* common/isaPkg.sv */
package isaPkg;

  typedef logic [5:0] opcodeT; // Primary opcode, instruction[31:26]
  typedef logic [5:0] functT;  // R-type funct, instruction[5:0]

  // ALU operation handed to execute
  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr  = 4'd3,
    aluSlt = 4'd4,
    aluSll = 4'd5,
    aluLui = 4'd6  // Pass operand 1 through
  } aluCtrlE;

  typedef enum logic [1:0] {
    immSign  = 2'd0,
    immZero  = 2'd1,
    immUpper = 2'd2
  } immKindE;

  //////////////////////////////////////////////////////////////////////
  // Opcode encodings
  localparam opcodeT opRType  = 6'h00;
  localparam opcodeT opRegImm = 6'h01; // bltz / bgez, picked by rt
  localparam opcodeT opJ      = 6'h02;
  localparam opcodeT opJal    = 6'h03;
  localparam opcodeT opBeq    = 6'h04;
  localparam opcodeT opBne    = 6'h05;
  localparam opcodeT opAddi   = 6'h08;
  localparam opcodeT opAndi   = 6'h0c;
  localparam opcodeT opOri    = 6'h0d;
  localparam opcodeT opLui    = 6'h0f;
  localparam opcodeT opLb     = 6'h20;
  localparam opcodeT opLh     = 6'h21;
  localparam opcodeT opLw     = 6'h23;
  localparam opcodeT opSb     = 6'h28;
  localparam opcodeT opSh     = 6'h29;
  localparam opcodeT opSw     = 6'h2b;

  // Funct encodings
  localparam functT functSll = 6'h00;
  localparam functT functJr  = 6'h08;
  localparam functT functAdd = 6'h20;
  localparam functT functSub = 6'h22;
  localparam functT functAnd = 6'h24;
  localparam functT functOr  = 6'h25;
  localparam functT functSlt = 6'h2a;

  localparam logic [4:0] rtBltz = 5'd0; // REGIMM rt field
  localparam logic [4:0] rtBgez = 5'd1;

endpackage
